// ==== Makefile ====
TOP := tb_instr_queue

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o sim

run: build
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module instr_queue_top

clean:
	rm -rf obj_dir

// ==== all.f ====
queue_cfg_pkg.sv
instr_pkg.sv
bank_fifo.sv
multi_port_fifo.sv
fetch_compactor.sv
instr_queue_top.sv
tb_instr_queue.sv

// ==== bank_fifo.sv ====
`timescale 1ns/1ps

module bank_fifo
  import queue_cfg_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              push_i,
  input  logic              pop_i,
  input  logic [SLOT_W-1:0] data_i,
  output logic [SLOT_W-1:0] data_o,
  output logic              full_o,
  output logic              empty_o
);

  logic [SLOT_W-1:0]     mem [BANK_DEPTH];
  logic [BANK_PTR_W-1:0] wr_ptr;
  logic [BANK_PTR_W-1:0] rd_ptr;
  logic [BANK_CNT_W-1:0] count;

  // ===================================================================
  // Pointers and occupancy
  // ===================================================================

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Head entry is always on the output
  assign data_o  = mem[rd_ptr];
  assign full_o  = (count == BANK_CNT_W'(BANK_DEPTH));
  assign empty_o = (count == '0);

  // The parent must never overrun or underrun a bank
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    push_i && full_o |-> flush_i)
    else $error("bank_fifo: push while full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
    pop_i && empty_o |-> flush_i)
    else $error("bank_fifo: pop while empty");

endmodule

// ==== fetch_compactor.sv ====
`timescale 1ns/1ps

module fetch_compactor
  import queue_cfg_pkg::*;
  import instr_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  input  logic                    fetch_valid_i,
  input  fetch_group_t            fetch_group_i,
  output logic                    fetch_ready_o,
  output logic        [LANES-1:0] write_valid_o,
  output instr_slot_t [LANES-1:0] write_data_o,
  input  logic                    write_ready_i
);

  logic [LANE_CNT_W-1:0]   fill_cnt;
  logic [LANES-1:0]        pack_valid;
  instr_slot_t [LANES-1:0] pack_data;
  logic                    fetch_fire;
  logic [LANES-1:0]        valid_q;
  instr_slot_t [LANES-1:0] data_q;

  // ===================================================================
  // Compaction
  // ===================================================================

  // Running count of valid slots below slot j gives its target lane
  always_comb begin
    fill_cnt  = '0;
    pack_data = '0;
    for (int j = 0; j < LANES; j++) begin
      if (fetch_group_i.mask[j]) begin
        pack_data[fill_cnt[LANE_IDX_W-1:0]] = fetch_group_i.slot[j];
        fill_cnt = fill_cnt + 1'b1;
      end
    end
  end

  // Lanes below the count are valid
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      pack_valid[i] = (fill_cnt > LANE_CNT_W'(i));
    end
  end

  // ===================================================================
  // Output register
  // ===================================================================

  // Free when empty or drained into the FIFO this cycle
  assign fetch_ready_o = ~(|valid_q) || write_ready_i;
  assign fetch_fire    = fetch_valid_i && fetch_ready_o;

  // An all-zero mask loads an empty register, so the group is dropped
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fetch_fire) begin
      valid_q <= pack_valid;
    end else if (write_ready_i) begin
      valid_q <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_fire) begin
      data_q <= pack_data;
    end
  end

  assign write_valid_o = valid_q;
  assign write_data_o  = data_q;

  // Held group must not change under back-pressure
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (|write_valid_o) && !write_ready_i && !flush_i
      |=> $stable(write_valid_o) && $stable(write_data_o))
    else $error("fetch_compactor: write group changed while stalled");

endmodule

// ==== instr_pkg.sv ====
package instr_pkg;

  import queue_cfg_pkg::*;

  // ===================================================================
  // Instruction encoding
  // ===================================================================

  typedef enum logic [1:0] {
    OP_ALU,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH
  } opcode_e;

  // One instruction slot, also the FIFO data word
  typedef struct packed {
    logic [31:0] pc;
    opcode_e     op;
    logic [15:0] imm;
  } instr_slot_t;

  // ===================================================================
  // Fetch group
  // ===================================================================

  // Sparse group from fetch, mask bit i qualifies slot i
  typedef struct packed {
    instr_slot_t [LANES-1:0] slot;
    logic        [LANES-1:0] mask;
  } fetch_group_t;

endpackage

// ==== instr_queue_top.sv ====
`timescale 1ns/1ps

module instr_queue_top
  import queue_cfg_pkg::*;
  import instr_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  input  logic                    fetch_valid_i,
  input  fetch_group_t            fetch_group_i,
  output logic                    fetch_ready_o,
  output logic        [LANES-1:0] decode_valid_o,
  output instr_slot_t [LANES-1:0] decode_data_o,
  input  logic        [LANES-1:0] decode_ready_i
);

  // Compacted write group into the FIFO
  logic        [LANES-1:0] write_valid;
  instr_slot_t [LANES-1:0] write_data;
  logic                    write_ready;

  fetch_compactor u_compactor (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_group_i (fetch_group_i),
    .fetch_ready_o (fetch_ready_o),
    .write_valid_o (write_valid),
    .write_data_o  (write_data),
    .write_ready_i (write_ready)
  );

  multi_port_fifo u_fifo (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .write_valid_i (write_valid),
    .write_data_i  (write_data),
    .write_ready_o (write_ready),
    .read_valid_o  (decode_valid_o),
    .read_ready_i  (decode_ready_i),
    .read_data_o   (decode_data_o)
  );

endmodule

// ==== multi_port_fifo.sv ====
`timescale 1ns/1ps

module multi_port_fifo
  import queue_cfg_pkg::*;
  import instr_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  input  logic        [LANES-1:0] write_valid_i,
  input  instr_slot_t [LANES-1:0] write_data_i,
  output logic                    write_ready_o,
  output logic        [LANES-1:0] read_valid_o,
  input  logic        [LANES-1:0] read_ready_i,
  output instr_slot_t [LANES-1:0] read_data_o
);

  logic [LANE_CNT_W-1:0] write_num;
  logic [LANE_CNT_W-1:0] read_num;
  logic [LANE_CNT_W-1:0] full_cnt;
  logic                  write_fire;

  // Per bank: which lane it takes next on write and on read
  logic [LANE_IDX_W-1:0] bank_wr_idx [BANKS];
  logic [LANE_IDX_W-1:0] bank_rd_idx [BANKS];
  // Per lane: which bank holds its entry
  logic [LANE_IDX_W-1:0] lane_bank [LANES];

  logic [BANKS-1:0]  bank_push;
  logic [BANKS-1:0]  bank_pop;
  logic [BANKS-1:0]  bank_full;
  logic [BANKS-1:0]  bank_empty;
  logic [SLOT_W-1:0] bank_din  [BANKS];
  logic [SLOT_W-1:0] bank_dout [BANKS];

  // True for masks of the form 0..01..1
  function automatic logic is_prefix(logic [LANES-1:0] m);
    logic [LANES-1:0] nxt;
    nxt = m + 1'b1;
    return (nxt & m) == '0;
  endfunction

  // ===================================================================
  // Group sizes and write acceptance
  // ===================================================================

  always_comb begin
    write_num = '0;
    read_num  = '0;
    full_cnt  = '0;
    for (int i = 0; i < LANES; i++) begin
      write_num = write_num + LANE_CNT_W'(write_valid_i[i]);
      read_num  = read_num + LANE_CNT_W'(read_ready_i[i]);
    end
    for (int b = 0; b < BANKS; b++) begin
      full_cnt = full_cnt + LANE_CNT_W'(bank_full[b]);
    end
  end

  // Enough free banks for a full-width group
  assign write_ready_o = (full_cnt <= LANE_CNT_W'(BANKS - LANES));
  assign write_fire    = (|write_valid_i) && write_ready_o;

  // ===================================================================
  // Banks with rotating indices
  // ===================================================================

  for (genvar b = 0; b < BANKS; b++) begin : g_bank
    always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        bank_wr_idx[b] <= LANE_IDX_W'(b);
        bank_rd_idx[b] <= LANE_IDX_W'(b);
      end else if (flush_i) begin
        bank_wr_idx[b] <= LANE_IDX_W'(b);
        bank_rd_idx[b] <= LANE_IDX_W'(b);
      end else begin
        if (write_fire) begin
          bank_wr_idx[b] <= bank_wr_idx[b] - write_num[LANE_IDX_W-1:0];
        end
        bank_rd_idx[b] <= bank_rd_idx[b] - read_num[LANE_IDX_W-1:0];
      end
    end

    // Bank takes part only if its lane index falls inside the group
    assign bank_push[b] = write_fire && (LANE_CNT_W'(bank_wr_idx[b]) < write_num);
    assign bank_pop[b]  = (LANE_CNT_W'(bank_rd_idx[b]) < read_num);
    assign bank_din[b]  = write_data_i[bank_wr_idx[b]];

    bank_fifo u_bank (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .flush_i (flush_i),
      .push_i  (bank_push[b]),
      .pop_i   (bank_pop[b]),
      .data_i  (bank_din[b]),
      .data_o  (bank_dout[b]),
      .full_o  (bank_full[b]),
      .empty_o (bank_empty[b])
    );
  end

  // ===================================================================
  // Read lane mapping
  // ===================================================================

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        lane_bank[l] <= LANE_IDX_W'(l);
      end else if (flush_i) begin
        lane_bank[l] <= LANE_IDX_W'(l);
      end else begin
        lane_bank[l] <= lane_bank[l] + read_num[LANE_IDX_W-1:0];
      end
    end

    // Lane 0 always maps to the bank holding the oldest entry
    assign read_valid_o[l] = ~bank_empty[lane_bank[l]];
    assign read_data_o[l]  = instr_slot_t'(bank_dout[lane_bank[l]]);
  end

  // Port contracts
  a_write_prefix: assert property (@(posedge clk) disable iff (!rst_n_i)
    is_prefix(write_valid_i))
    else $error("multi_port_fifo: write_valid_i not contiguous from lane 0");

  a_read_prefix: assert property (@(posedge clk) disable iff (!rst_n_i)
    is_prefix(read_ready_i))
    else $error("multi_port_fifo: read_ready_i not contiguous from lane 0");

  a_read_on_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    (read_ready_i & ~read_valid_o) == '0)
    else $error("multi_port_fifo: read_ready_i set on an empty lane");

endmodule

// ==== queue_cfg_pkg.sv ====
package queue_cfg_pkg;

  // ===================================================================
  // Queue geometry
  // ===================================================================

  // Fetch and decode width
  localparam int LANES = 4;

  // One bank per lane
  localparam int BANKS = LANES;

  localparam int QUEUE_DEPTH = 16;
  localparam int BANK_DEPTH  = QUEUE_DEPTH / BANKS;

  // ===================================================================
  // Index, count and pointer widths
  // ===================================================================

  // Bank or lane select
  localparam int LANE_IDX_W = $clog2(LANES);
  // Count from 0 to LANES inclusive
  localparam int LANE_CNT_W = $clog2(LANES + 1);

  // Per-bank read/write pointer and occupancy
  localparam int BANK_PTR_W = $clog2(BANK_DEPTH);
  localparam int BANK_CNT_W = $clog2(BANK_DEPTH + 1);

  // Width of one stored instruction slot
  localparam int SLOT_W = 50;

endpackage

// ==== tb_instr_queue.sv ====
`timescale 1ns/1ps

module tb_instr_queue
  import queue_cfg_pkg::*;
  import instr_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int NUM_CYCLES  = 3000;
  localparam int STALL_START = 600;
  localparam int STALL_LEN   = 150;

  logic                    clk = 1'b0;
  logic                    rst_n_i;
  logic                    flush_i;
  logic                    fetch_valid_i;
  fetch_group_t            fetch_group_i;
  logic                    fetch_ready_o;
  logic        [LANES-1:0] decode_valid_o;
  instr_slot_t [LANES-1:0] decode_data_o;
  logic        [LANES-1:0] decode_ready_i;

  // Stimulus state
  logic [31:0] rng_state   = 32'h636;
  logic [31:0] pc_base     = 32'h0000_1000;
  int          stall_cnt   = 0;
  logic        fetch_taken = 1'b0;
  int          ready_limit = 0;

  // Reference model
  instr_slot_t model_q [$];
  logic [31:0] pc_floor   = '0;
  logic [31:0] acc_pc_end = '0;
  logic        flush_prev = 1'b0;
  logic        rst_prev   = 1'b0;
  int          pop_total  = 0;
  int          flush_cnt  = 0;
  logic        stall_seen = 1'b0;

  // Check results updated mid-cycle
  logic  reset_ok       = 1'b1;
  logic  flush_clear_ok = 1'b1;
  logic  pop_ok         = 1'b1;
  logic  head_ok        = 1'b1;
  logic  vis_ok         = 1'b1;
  logic  floor_ok       = 1'b1;
  logic  stall_ok       = 1'b1;
  string detail         = "";

  instr_queue_top DUT (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_group_i  (fetch_group_i),
    .fetch_ready_o  (fetch_ready_o),
    .decode_valid_o (decode_valid_o),
    .decode_data_o  (decode_data_o),
    .decode_ready_i (decode_ready_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ===================================================================
  // Helpers
  // ===================================================================

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic int count_ones(logic [LANES-1:0] v);
    int n;
    n = 0;
    for (int i = 0; i < LANES; i++) begin
      if (v[i]) begin
        n = n + 1;
      end
    end
    return n;
  endfunction

  function automatic logic [LANES-1:0] prefix_mask(int n);
    logic [LANES-1:0] m;
    for (int i = 0; i < LANES; i++) begin
      m[i] = (i < n);
    end
    return m;
  endfunction

  // Next fetch group with PCs stepping by 4 per slot position
  function automatic fetch_group_t new_group();
    fetch_group_t g;
    logic [31:0]  r;
    for (int j = 0; j < LANES; j++) begin
      r = next_random();
      g.slot[j].pc  = pc_base + 32'(4 * j);
      g.slot[j].op  = opcode_e'(r[1:0]);
      g.slot[j].imm = r[31:16];
    end
    r = next_random();
    // Half the groups get an extra sparse mask
    g.mask  = r[8] ? (r[LANES-1:0] & r[2*LANES-1:LANES]) : r[LANES-1:0];
    pc_base = pc_base + 32'(4 * LANES);
    return g;
  endfunction

  task automatic report_failure(input string what);
    $display("ERROR %0t: %s", $time, what);
    $display("Result: FAILED");
    $fatal(1, "check failed");
  endtask

  // One cycle of fetch, flush and decode stimulus
  task automatic drive_inputs(input int cyc);
    logic [31:0] r;
    logic        stall;
    int          take;
    r     = next_random();
    stall = ((cyc % 1000) >= STALL_START) && ((cyc % 1000) < STALL_START + STALL_LEN + 20);
    stall_cnt <= stall ? stall_cnt + 1 : 0;
    flush_i   <= !stall && (r[15:8] == 8'h00);
    // Hold an offered group until it is taken
    if (fetch_taken || !fetch_valid_i) begin
      if (r[1:0] != 2'b00) begin
        fetch_group_i <= new_group();
        fetch_valid_i <= 1'b1;
      end else begin
        fetch_valid_i <= 1'b0;
      end
    end
    take = int'(r[23:16]) % (ready_limit + 1);
    if (stall) begin
      take = 0;
    end
    decode_ready_i <= prefix_mask(take);
  endtask

  // ===================================================================
  // Reference model and mid-cycle checks
  // ===================================================================

  always @(negedge clk) begin
    int   valid_cnt;
    int   pop_cnt;
    logic taken;
    valid_cnt = count_ones(decode_valid_o);
    pop_cnt   = count_ones(decode_ready_i);
    taken     = fetch_valid_i && fetch_ready_o;

    reset_ok = rst_prev || !rst_n_i || (decode_valid_o == '0 && fetch_ready_o);
    if (!reset_ok) begin
      detail = $sformatf("valid %b ready %b", decode_valid_o, fetch_ready_o);
    end
    flush_clear_ok = !flush_prev || (decode_valid_o == '0 && fetch_ready_o);
    if (!flush_clear_ok) begin
      detail = $sformatf("valid %b ready %b after flush", decode_valid_o, fetch_ready_o);
    end

    pop_ok   = 1'b1;
    head_ok  = 1'b1;
    vis_ok   = 1'b1;
    floor_ok = 1'b1;
    for (int l = 0; l < LANES; l++) begin
      if (decode_valid_o[l] && l >= model_q.size()) begin
        vis_ok = 1'b0;
        detail = $sformatf("lane %0d valid, model holds %0d", l, model_q.size());
      end
      if (decode_valid_o[l] && decode_data_o[l].pc < pc_floor) begin
        floor_ok = 1'b0;
        detail   = $sformatf("lane %0d pc %h older than flush point %h",
                             l, decode_data_o[l].pc, pc_floor);
      end
      if (decode_ready_i[l] && l < model_q.size()) begin
        if (decode_data_o[l] != model_q[l]) begin
          pop_ok = 1'b0;
          detail = $sformatf("lane %0d got pc %h %s imm %h, expected pc %h %s imm %h", l,
                             decode_data_o[l].pc, decode_data_o[l].op.name(),
                             decode_data_o[l].imm, model_q[l].pc, model_q[l].op.name(),
                             model_q[l].imm);
        end
      end else if (decode_ready_i[l]) begin
        pop_ok = 1'b0;
        detail = $sformatf("lane %0d popped with empty model", l);
      end
    end
    if (decode_valid_o[0] && model_q.size() > 0 && decode_data_o[0] != model_q[0]) begin
      head_ok = 1'b0;
      detail  = $sformatf("lane 0 pc %h, oldest model pc %h",
                          decode_data_o[0].pc, model_q[0].pc);
    end

    stall_ok = (stall_cnt != STALL_LEN) || !fetch_ready_o;
    if (!stall_ok) begin
      detail = $sformatf("fetch_ready_o still high after %0d stalled cycles", STALL_LEN);
    end else if (stall_cnt == STALL_LEN) begin
      stall_seen = 1'b1;
    end

    // Apply this cycle's transfers
    if (taken) begin
      acc_pc_end = fetch_group_i.slot[LANES-1].pc + 32'd4;
    end
    if (flush_i) begin
      model_q.delete();
      pc_floor  = acc_pc_end;
      flush_cnt = flush_cnt + 1;
    end else begin
      for (int k = 0; k < pop_cnt; k++) begin
        if (model_q.size() > 0) begin
          void'(model_q.pop_front());
        end
      end
      pop_total = pop_total + pop_cnt;
      if (taken) begin
        for (int j = 0; j < LANES; j++) begin
          if (fetch_group_i.mask[j]) begin
            model_q.push_back(fetch_group_i.slot[j]);
          end
        end
      end
    end

    // Lower bound on lanes valid next cycle
    ready_limit = flush_i ? 0 : valid_cnt - pop_cnt;
    fetch_taken = taken;
    flush_prev  = flush_i;
    rst_prev    = rst_n_i;
  end

  a_reset_idle: assert property (@(posedge clk) reset_ok)
    else report_failure({"outputs not idle after reset: ", detail});

  a_flush_clear: assert property (@(posedge clk) disable iff (!rst_n_i) flush_clear_ok)
    else report_failure({"queue not idle after flush: ", detail});

  a_pop_data: assert property (@(posedge clk) disable iff (!rst_n_i) pop_ok)
    else report_failure({"popped entry mismatch: ", detail});

  a_head_order: assert property (@(posedge clk) disable iff (!rst_n_i) head_ok)
    else report_failure({"oldest entry mismatch: ", detail});

  a_valid_held: assert property (@(posedge clk) disable iff (!rst_n_i) vis_ok)
    else report_failure({"valid lane without entry: ", detail});

  a_flush_drop: assert property (@(posedge clk) disable iff (!rst_n_i) floor_ok)
    else report_failure({"flushed entry reappeared: ", detail});

  a_backpressure: assert property (@(posedge clk) disable iff (!rst_n_i) stall_ok)
    else report_failure({"no back-pressure: ", detail});

  // ===================================================================
  // Stimulus and end of run
  // ===================================================================

  initial begin
    rst_n_i        <= 1'b0;
    flush_i        <= 1'b0;
    fetch_valid_i  <= 1'b0;
    fetch_group_i  <= '0;
    decode_ready_i <= '0;
    repeat (2) @(posedge clk);
    rst_n_i <= 1'b1;
    for (int c = 0; c < NUM_CYCLES; c++) begin
      @(posedge clk);
      drive_inputs(c);
    end
    // Let the assertions of the last edge complete
    @(posedge clk);
    #(CLK_PERIOD / 4);
    if (pop_total > 0 && flush_cnt > 0 && stall_seen) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Stimulus missed a case: %0d pops, %0d flushes, stall seen %0b",
               pop_total, flush_cnt, stall_seen);
      $display("Result: FAILED");
      $fatal(1, "incomplete stimulus");
    end
  end

  // Watchdog
  initial begin
    #((NUM_CYCLES + 100) * CLK_PERIOD);
    $display("Timeout: run did not end within %0d clock cycles", NUM_CYCLES + 100);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule
